// ==== include/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path width.
`define XLEN 32

// byte address width of both memories.
`define PC_WIDTH 14

// first fetch address after reset.
`define RESET_PC 14'd0

// addi x0, x0, 0.
`define NOP_INSTR 32'h0000_0013

`endif

// ==== hdl/isaPkg.sv ====
`default_nettype none

package isaPkg;

    // ----------------------------------------------------------
    // major opcodes, bits [6:0] of the instruction word.
    // ----------------------------------------------------------
    typedef enum logic [6:0] {
        opcArith    = 7'b0110011,
        opcArithImm = 7'b0010011,
        opcLui      = 7'b0110111,
        opcAuipc    = 7'b0010111,
        opcJal      = 7'b1101111,
        opcJalr     = 7'b1100111,
        opcBranch   = 7'b1100011,
        opcLoad     = 7'b0000011
    } opcode_e;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOp_e;

    // encoded as funct3 so decode can cast it straight across.
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } brCond_e;

endpackage

`default_nettype wire

// ==== hdl/pipePkg.sv ====
`default_nettype none

`include "core_cfg.svh"

package pipePkg;

    // ----------------------------------------------------------
    // execute stage register.
    // ----------------------------------------------------------
    typedef struct packed {
        logic [`PC_WIDTH-1:0] pc;
        isaPkg::opcode_e      opcode;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic [`XLEN-1:0]     imm;
        isaPkg::aluOp_e       aluOp;
        isaPkg::brCond_e      brCond;
        logic                 aSelPc;
        logic                 bSelImm;
        logic                 regWrite;
    } xStage_t;

    // ----------------------------------------------------------
    // writeback stage register, also the retire record.
    // ----------------------------------------------------------
    typedef struct packed {
        logic [`PC_WIDTH-1:0] pc;
        isaPkg::opcode_e      opcode;
        logic [4:0]           rd;
        logic [`XLEN-1:0]     result;
        logic                 regWrite;
    } wStage_t;

endpackage

`default_nettype wire

// ==== hdl/hazardIf.sv ====
`default_nettype none

`include "core_cfg.svh"

interface hazardIf;
    // pipeline state seen by the controller.
    isaPkg::opcode_e      opcodeW;
    isaPkg::opcode_e      opcodeX;
    logic [4:0]           rdW;
    logic [4:0]           rs1X;
    logic [4:0]           rs2X;
    logic [`PC_WIDTH-1:0] pcX;
    logic [`PC_WIDTH-1:0] pcW;
    logic                 stall;

    // decisions back to the datapath.
    logic forwardA;
    logic forwardB;
    logic delayW;
    logic holdX;
    logic squashF;

    modport datapath (
        output opcodeW, opcodeX, rdW, rs1X, rs2X, pcX, pcW, stall,
        input  forwardA, forwardB, delayW, holdX, squashF
    );

    modport control (
        input  opcodeW, opcodeX, rdW, rs1X, rs2X, pcX, pcW, stall,
        output forwardA, forwardB, delayW, holdX, squashF
    );
endinterface

`default_nettype wire

// ==== hdl/hazardController.sv ====
`default_nettype none

module hazardController (
    hazardIf.control hz
);
    logic wWrites;
    logic wIsLoad;
    logic matchA;
    logic matchB;
    logic loadUse;

    // ----------------------------------------------------------
    // what sits in W.
    // ----------------------------------------------------------
    always_comb begin
        wWrites = 1'b0;
        wIsLoad = 1'b0;
        case (hz.opcodeW)
            isaPkg::opcArith,
            isaPkg::opcArithImm,
            isaPkg::opcLui,
            isaPkg::opcAuipc,
            isaPkg::opcJal,
            isaPkg::opcJalr: wWrites = 1'b1;
            isaPkg::opcLoad: wIsLoad = 1'b1;
            default: wWrites = 1'b0;
        endcase
    end

    // x0 never carries a dependency.
    assign matchA = (hz.rdW != 5'd0) && (hz.rdW == hz.rs1X);
    assign matchB = (hz.rdW != 5'd0) && (hz.rdW == hz.rs2X);

    // a held instruction must not pick up its own result.
    assign hz.forwardA = wWrites && matchA && (hz.pcX != hz.pcW);
    assign hz.forwardB = wWrites && matchB && (hz.pcX != hz.pcW);

    // load data reaches X through the register file one cycle later.
    assign loadUse  = wIsLoad && (matchA || matchB);
    assign hz.delayW = loadUse && !hz.stall;
    assign hz.holdX  = loadUse || hz.stall;

    // ----------------------------------------------------------
    // control transfer in X kills the slot behind it.
    // ----------------------------------------------------------
    always_comb begin
        case (hz.opcodeX)
            isaPkg::opcBranch,
            isaPkg::opcJal,
            isaPkg::opcJalr: hz.squashF = 1'b1;
            default: hz.squashF = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/decodeUnit.sv ====
`default_nettype none

`include "core_cfg.svh"

module decodeUnit (
    input  wire logic [`XLEN-1:0] instr,
    output isaPkg::opcode_e       opcode,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd,
    output logic [`XLEN-1:0]      imm,
    output isaPkg::aluOp_e        aluOp,
    output isaPkg::brCond_e       brCond,
    output logic                  aSelPc,
    output logic                  bSelImm,
    output logic                  regWrite
);
    logic [2:0]       funct3;
    logic             funct7b5;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] immJ;
    logic [`XLEN-1:0] immB;
    isaPkg::aluOp_e   funcOp;

    assign opcode   = isaPkg::opcode_e'(instr[6:0]);
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign brCond   = isaPkg::brCond_e'(funct3);

    // ----------------------------------------------------------
    // immediate formats.
    // ----------------------------------------------------------
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // funct3 map, sub only exists in the register form.
    always_comb begin
        case (funct3)
            3'b000: funcOp = (funct7b5 && opcode == isaPkg::opcArith) ?
                             isaPkg::aluSub : isaPkg::aluAdd;
            3'b001: funcOp = isaPkg::aluSll;
            3'b010: funcOp = isaPkg::aluSlt;
            3'b011: funcOp = isaPkg::aluSltu;
            3'b100: funcOp = isaPkg::aluXor;
            3'b101: funcOp = funct7b5 ? isaPkg::aluSra : isaPkg::aluSrl;
            3'b110: funcOp = isaPkg::aluOr;
            default: funcOp = isaPkg::aluAnd;
        endcase
    end

    // ----------------------------------------------------------
    // per-opcode controls.
    // ----------------------------------------------------------
    always_comb begin
        rs1      = instr[19:15];
        rs2      = 5'd0;
        imm      = immI;
        aluOp    = isaPkg::aluAdd;
        aSelPc   = 1'b0;
        bSelImm  = 1'b1;
        regWrite = 1'b1;
        case (opcode)
            isaPkg::opcArith: begin
                rs2     = instr[24:20];
                aluOp   = funcOp;
                bSelImm = 1'b0;
            end
            isaPkg::opcArithImm: begin
                aluOp = funcOp;
            end
            isaPkg::opcLui: begin
                rs1   = 5'd0;
                imm   = immU;
                aluOp = isaPkg::aluPassB;
            end
            isaPkg::opcAuipc: begin
                rs1    = 5'd0;
                imm    = immU;
                aSelPc = 1'b1;
            end
            isaPkg::opcJal: begin
                rs1    = 5'd0;
                imm    = immJ;
                aSelPc = 1'b1;
            end
            isaPkg::opcJalr,
            isaPkg::opcLoad: begin
                imm = immI;
            end
            isaPkg::opcBranch: begin
                rs2      = instr[24:20];
                imm      = immB;
                bSelImm  = 1'b0;
                regWrite = 1'b0;
            end
            default: begin
                // unsupported encodings retire nothing.
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`default_nettype none

`include "core_cfg.svh"

module regFile (
    input  wire logic             clk,
    input  wire logic             arstN,
    input  wire logic [4:0]       rs1,
    input  wire logic [4:0]       rs2,
    output logic [`XLEN-1:0]      rdata1,
    output logic [`XLEN-1:0]      rdata2,
    input  wire logic             we,
    input  wire logic [4:0]       wAddr,
    input  wire logic [`XLEN-1:0] wData
);
    // x0 has no storage.
    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != 5'd0) begin
            regs[wAddr] <= wData;
        end
    end

    // ----------------------------------------------------------
    // read ports with write-through bypass.
    // ----------------------------------------------------------
    always_comb begin
        if (rs1 == 5'd0)
            rdata1 = '0;
        else if (we && wAddr == rs1)
            rdata1 = wData;
        else
            rdata1 = regs[rs1];

        if (rs2 == 5'd0)
            rdata2 = '0;
        else if (we && wAddr == rs2)
            rdata2 = wData;
        else
            rdata2 = regs[rs2];
    end

endmodule

`default_nettype wire

// ==== hdl/aluUnit.sv ====
`default_nettype none

`include "core_cfg.svh"

module aluUnit (
    input  wire logic [`XLEN-1:0] a,
    input  wire logic [`XLEN-1:0] b,
    input  isaPkg::aluOp_e        op,
    input  isaPkg::brCond_e       cond,
    input  wire logic             isBranch,
    output logic [`XLEN-1:0]      result,
    output logic                  taken
);
    logic       lessS;
    logic       lessU;
    logic [4:0] shamt;

    assign lessS = $signed(a) < $signed(b);
    assign lessU = a < b;
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            isaPkg::aluAdd:   result = a + b;
            isaPkg::aluSub:   result = a - b;
            isaPkg::aluSll:   result = a << shamt;
            isaPkg::aluSlt:   result = {{(`XLEN-1){1'b0}}, lessS};
            isaPkg::aluSltu:  result = {{(`XLEN-1){1'b0}}, lessU};
            isaPkg::aluXor:   result = a ^ b;
            isaPkg::aluSrl:   result = a >> shamt;
            isaPkg::aluSra:   result = $signed(a) >>> shamt;
            isaPkg::aluOr:    result = a | b;
            isaPkg::aluAnd:   result = a & b;
            isaPkg::aluPassB: result = b;
            default:          result = '0;
        endcase
    end

    // ----------------------------------------------------------
    // branch decision on the register operands.
    // ----------------------------------------------------------
    always_comb begin
        case (cond)
            isaPkg::brEq:  taken = isBranch && (a == b);
            isaPkg::brNe:  taken = isBranch && (a != b);
            isaPkg::brLt:  taken = isBranch && lessS;
            isaPkg::brGe:  taken = isBranch && !lessS;
            isaPkg::brLtu: taken = isBranch && lessU;
            isaPkg::brGeu: taken = isBranch && !lessU;
            default:       taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/coreTop.sv ====
`default_nettype none

`include "core_cfg.svh"

module coreTop (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire logic                 stall,
    output logic [`PC_WIDTH-1:0]      imemAddr,
    input  wire logic [`XLEN-1:0]     imemData,
    output logic [`PC_WIDTH-1:0]      dmemAddr,
    input  wire logic [`XLEN-1:0]     dmemRdata,
    output logic                      retireValid,
    output logic [`PC_WIDTH-1:0]      retirePc,
    output logic [4:0]                retireRd,
    output logic [`XLEN-1:0]          retireData
);
    // empty slots, never written back.
    localparam pipePkg::xStage_t X_NOP = '{
        pc: '0, opcode: isaPkg::opcArithImm, rs1: '0, rs2: '0, rd: '0, imm: '0,
        aluOp: isaPkg::aluAdd, brCond: isaPkg::brEq, aSelPc: 1'b0, bSelImm: 1'b1,
        regWrite: 1'b0
    };
    localparam pipePkg::wStage_t W_NOP = '{
        pc: '0, opcode: isaPkg::opcArithImm, rd: '0, result: '0, regWrite: 1'b0
    };

    logic [`PC_WIDTH-1:0] pc;
    logic [`PC_WIDTH-1:0] pcNext;
    logic [`PC_WIDTH-1:0] target;
    pipePkg::xStage_t     xReg;
    pipePkg::xStage_t     xNext;
    pipePkg::wStage_t     wReg;
    pipePkg::wStage_t     wNext;

    logic [`XLEN-1:0]     fetchInstr;
    isaPkg::opcode_e      decOpcode;
    logic [4:0]           decRs1;
    logic [4:0]           decRs2;
    logic [4:0]           decRd;
    logic [`XLEN-1:0]     decImm;
    isaPkg::aluOp_e       decAluOp;
    isaPkg::brCond_e      decBrCond;
    logic                 decASelPc;
    logic                 decBSelImm;
    logic                 decRegWrite;

    logic [`XLEN-1:0]     rdata1;
    logic [`XLEN-1:0]     rdata2;
    logic [`XLEN-1:0]     opA;
    logic [`XLEN-1:0]     opB;
    logic [`XLEN-1:0]     aluA;
    logic [`XLEN-1:0]     aluB;
    logic [`XLEN-1:0]     aluResult;
    logic [`XLEN-1:0]     linkValue;
    logic [`XLEN-1:0]     xResult;
    logic                 isBranch;
    logic                 isJump;
    logic                 taken;

    hazardIf hz ();

    assign hz.opcodeW = wReg.opcode;
    assign hz.opcodeX = xReg.opcode;
    assign hz.rdW     = wReg.rd;
    assign hz.rs1X    = xReg.rs1;
    assign hz.rs2X    = xReg.rs2;
    assign hz.pcX     = xReg.pc;
    assign hz.pcW     = wReg.pc;
    assign hz.stall   = stall;

    hazardController hazard_i (.hz(hz.control));

    // ----------------------------------------------------------
    // fetch and decode.
    // ----------------------------------------------------------
    assign imemAddr   = pc;
    assign fetchInstr = hz.squashF ? `NOP_INSTR : imemData;

    decodeUnit decode_i (
        .instr(fetchInstr), .opcode(decOpcode), .rs1(decRs1), .rs2(decRs2), .rd(decRd),
        .imm(decImm), .aluOp(decAluOp), .brCond(decBrCond), .aSelPc(decASelPc),
        .bSelImm(decBSelImm), .regWrite(decRegWrite)
    );

    always_comb begin
        xNext.pc       = pc;
        xNext.opcode   = decOpcode;
        xNext.rs1      = decRs1;
        xNext.rs2      = decRs2;
        xNext.rd       = decRd;
        xNext.imm      = decImm;
        xNext.aluOp    = decAluOp;
        xNext.brCond   = decBrCond;
        xNext.aSelPc   = decASelPc;
        xNext.bSelImm  = decBSelImm;
        // squashed slot travels as a bubble.
        xNext.regWrite = decRegWrite && !hz.squashF;
    end

    // ----------------------------------------------------------
    // execute.
    // ----------------------------------------------------------
    regFile regs_i (
        .clk(clk), .arstN(arstN), .rs1(xReg.rs1), .rs2(xReg.rs2),
        .rdata1(rdata1), .rdata2(rdata2),
        .we(wReg.regWrite && !stall), .wAddr(wReg.rd), .wData(wReg.result)
    );

    assign opA  = hz.forwardA ? wReg.result : rdata1;
    assign opB  = hz.forwardB ? wReg.result : rdata2;
    assign aluA = xReg.aSelPc ? {{(`XLEN-`PC_WIDTH){1'b0}}, xReg.pc} : opA;
    assign aluB = xReg.bSelImm ? xReg.imm : opB;

    assign isBranch = xReg.opcode == isaPkg::opcBranch;
    assign isJump   = xReg.opcode == isaPkg::opcJal || xReg.opcode == isaPkg::opcJalr;

    aluUnit alu_i (
        .a(aluA), .b(aluB), .op(xReg.aluOp), .cond(xReg.brCond),
        .isBranch(isBranch), .result(aluResult), .taken(taken)
    );

    assign dmemAddr  = aluResult[`PC_WIDTH-1:0];
    assign linkValue = {{(`XLEN-`PC_WIDTH){1'b0}}, xReg.pc + `PC_WIDTH'd4};

    always_comb begin
        if (isJump)
            xResult = linkValue;
        else if (xReg.opcode == isaPkg::opcLoad)
            xResult = dmemRdata;
        else
            xResult = aluResult;
    end

    // jalr clears bit 0, jal targets are already even.
    assign target = isBranch ? xReg.pc + xReg.imm[`PC_WIDTH-1:0] :
                               {aluResult[`PC_WIDTH-1:1], 1'b0};
    // a not-taken branch refetches its squashed fall-through.
    assign pcNext = (taken || isJump) ? target :
                    isBranch          ? xReg.pc + `PC_WIDTH'd4 :
                                        pc + `PC_WIDTH'd4;

    always_comb begin
        wNext.pc       = xReg.pc;
        wNext.opcode   = xReg.opcode;
        wNext.rd       = xReg.rd;
        wNext.result   = xResult;
        wNext.regWrite = xReg.regWrite;
    end

    // ----------------------------------------------------------
    // stage registers.
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc   <= `RESET_PC;
            xReg <= X_NOP;
            wReg <= W_NOP;
        end else begin
            if (!hz.holdX) begin
                pc   <= pcNext;
                xReg <= xNext;
            end
            if (!stall) begin
                wReg <= hz.delayW ? W_NOP : wNext;
            end
        end
    end

    // retirement is the writeback of W.
    assign retireValid = wReg.regWrite && !stall;
    assign retirePc    = wReg.pc;
    assign retireRd    = wReg.rd;
    assign retireData  = wReg.result;

endmodule

`default_nettype wire

// ==== test/coreTb.sv ====
`default_nettype none

`include "core_cfg.svh"

module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk;
    logic                 arstN;
    logic                 stall;
    logic [`PC_WIDTH-1:0] imemAddr;
    logic [`XLEN-1:0]     imemData;
    logic [`PC_WIDTH-1:0] dmemAddr;
    logic [`XLEN-1:0]     dmemRdata;
    logic                 retireValid;
    logic [`PC_WIDTH-1:0] retirePc;
    logic [4:0]           retireRd;
    logic [`XLEN-1:0]     retireData;

    logic [`XLEN-1:0]     imem [0:4095];
    logic [`XLEN-1:0]     dmem [0:4095];

    // expected retire table.
    logic [`PC_WIDTH-1:0] expPcArr [0:63];
    logic [4:0]           expRdArr [0:63];
    logic [`XLEN-1:0]     expDataArr [0:63];
    logic                 expBubbleArr [0:63];
    int                   expCount;
    int                   expIdx;
    logic [`PC_WIDTH-1:0] expPc;
    logic [4:0]           expRd;
    logic [`XLEN-1:0]     expData;
    logic                 expBubble;
    logic                 expLeft;

    int                   errors;
    int                   cycles;
    int                   stallCycles;
    int                   stallLeft;
    int                   seed;
    logic                 timedOut;

    coreTop dut_i (
        .clk(clk), .arstN(arstN), .stall(stall),
        .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemRdata(dmemRdata),
        .retireValid(retireValid), .retirePc(retirePc),
        .retireRd(retireRd), .retireData(retireData)
    );

    always #10 clk = ~clk;

    // both memories answer in the same cycle.
    assign imemData  = imem[imemAddr[13:2]];
    assign dmemRdata = dmem[dmemAddr[13:2]];

    assign expLeft   = expIdx < expCount;
    assign expPc     = expPcArr[expIdx[5:0]];
    assign expRd     = expRdArr[expIdx[5:0]];
    assign expData   = expDataArr[expIdx[5:0]];
    assign expBubble = expBubbleArr[expIdx[5:0]];

    // ------------------------------------------------------------
    // instruction encoders, straight from the RV32I formats.
    // ------------------------------------------------------------
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic putInstr(input int pc, input logic [31:0] instr);
        imem[pc >> 2] = instr;
    endtask

    task automatic addExpect(input int pc, input logic [4:0] rd, input logic [31:0] value,
                             input logic bubble);
        expPcArr[expCount]     = pc[`PC_WIDTH-1:0];
        expRdArr[expCount]     = rd;
        expDataArr[expCount]   = value;
        expBubbleArr[expCount] = bubble;
        expCount++;
    endtask

    task automatic loadProgram();
        logic [31:0] d0;
        logic [31:0] d1;
        d0 = dmem[64];
        d1 = dmem[65];
        // wrong-path marker, addi x20, x0, 2047.
        for (int i = 0; i < 4096; i++) begin
            imem[i] = encI(12'h7ff, 5'd0, 3'b000, 5'd20, 7'b0010011);
        end

        // dependent ALU chain.
        putInstr(0,  encI(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
        putInstr(4,  encI(12'd7, 5'd1, 3'b000, 5'd2, 7'b0010011));
        putInstr(8,  encR(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        putInstr(12, encR(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
        putInstr(16, encR(7'h00, 5'd4, 5'd2, 3'b001, 5'd5));
        putInstr(20, encI(12'd99, 5'd5, 3'b000, 5'd0, 7'b0010011));
        putInstr(24, encR(7'h00, 5'd5, 5'd0, 3'b000, 5'd6));
        putInstr(28, encI(12'hff0, 5'd0, 3'b000, 5'd7, 7'b0010011));
        putInstr(32, encI(12'h402, 5'd7, 3'b101, 5'd8, 7'b0010011));
        putInstr(36, encI(12'd28, 5'd7, 3'b101, 5'd9, 7'b0010011));
        putInstr(40, encR(7'h00, 5'd7, 5'd9, 3'b011, 5'd10));
        putInstr(44, encR(7'h00, 5'd9, 5'd7, 3'b010, 5'd11));
        putInstr(48, encR(7'h00, 5'd6, 5'd7, 3'b111, 5'd12));
        addExpect(0, 1, 32'd5, 0);
        addExpect(4, 2, 32'd12, 0);
        addExpect(8, 3, 32'd17, 0);
        addExpect(12, 4, 32'd5, 0);
        addExpect(16, 5, 32'd384, 0);
        addExpect(20, 0, 32'd483, 0);
        addExpect(24, 6, 32'd384, 0);
        addExpect(28, 7, 32'hffff_fff0, 0);
        addExpect(32, 8, 32'hffff_fffc, 0);
        addExpect(36, 9, 32'h0000_000f, 0);
        addExpect(40, 10, 32'd1, 0);
        addExpect(44, 11, 32'd1, 0);
        addExpect(48, 12, 32'd384, 0);

        // load-use pairs.
        putInstr(52, encI(12'h100, 5'd0, 3'b010, 5'd13, 7'b0000011));
        putInstr(56, encI(12'd3, 5'd13, 3'b000, 5'd14, 7'b0010011));
        putInstr(60, encI(12'h104, 5'd0, 3'b010, 5'd15, 7'b0000011));
        putInstr(64, encR(7'h00, 5'd15, 5'd14, 3'b000, 5'd16));
        addExpect(52, 13, d0, 0);
        addExpect(56, 14, d0 + 32'd3, 1);
        addExpect(60, 15, d1, 0);
        addExpect(64, 16, d0 + 32'd3 + d1, 1);

        // ------------------------------------------------------------
        // branches, x1 = 5, x7 = -16, x9 = 15.
        // ------------------------------------------------------------
        putInstr(68,  encB(13'd8, 5'd1, 5'd1, 3'b000));
        putInstr(76,  encB(13'd8, 5'd1, 5'd1, 3'b001));
        putInstr(80,  encI(12'd1, 5'd0, 3'b000, 5'd17, 7'b0010011));
        putInstr(84,  encB(13'd8, 5'd1, 5'd7, 3'b100));
        putInstr(92,  encB(13'd8, 5'd1, 5'd7, 3'b101));
        putInstr(96,  encI(12'd2, 5'd0, 3'b000, 5'd18, 7'b0010011));
        putInstr(100, encB(13'd8, 5'd1, 5'd7, 3'b110));
        putInstr(104, encI(12'd3, 5'd0, 3'b000, 5'd19, 7'b0010011));
        putInstr(108, encB(13'd8, 5'd1, 5'd7, 3'b111));
        putInstr(116, encB(13'd8, 5'd7, 5'd1, 3'b101));
        putInstr(124, encB(13'd8, 5'd7, 5'd1, 3'b100));
        putInstr(128, encB(13'd8, 5'd7, 5'd1, 3'b110));
        putInstr(136, encB(13'd8, 5'd7, 5'd1, 3'b111));
        putInstr(140, encB(13'd8, 5'd9, 5'd1, 3'b000));
        putInstr(144, encB(13'd8, 5'd9, 5'd1, 3'b001));
        addExpect(80, 17, 32'd1, 0);
        addExpect(96, 18, 32'd2, 0);
        addExpect(104, 19, 32'd3, 0);

        // jumps and upper immediates.
        putInstr(152, encJ(21'd12, 5'd21));
        putInstr(164, encU(20'h12345, 5'd22, 7'b0110111));
        putInstr(168, encU(20'h00001, 5'd23, 7'b0010111));
        putInstr(172, encI(12'd192, 5'd0, 3'b000, 5'd24, 7'b0010011));
        putInstr(176, encI(12'd8, 5'd24, 3'b000, 5'd25, 7'b1100111));
        putInstr(200, encI(12'd1, 5'd25, 3'b000, 5'd26, 7'b0010011));
        // park on a branch to itself, which never retires.
        putInstr(204, encB(13'd0, 5'd0, 5'd0, 3'b000));
        addExpect(152, 21, 32'd156, 0);
        addExpect(164, 22, 32'h1234_5000, 0);
        addExpect(168, 23, 32'd168 + 32'h1000, 0);
        addExpect(172, 24, 32'd192, 0);
        addExpect(176, 25, 32'd180, 0);
        addExpect(200, 26, 32'd181, 0);
    endtask

    // ------------------------------------------------------------
    // retire checks.
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (arstN && retireValid) begin
            expIdx <= expIdx + 1;
        end
    end

    retireExpected: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |-> expLeft)
    else begin
        errors++;
        $display("unexpected retirement of pc %0h beyond the table at %0t",
                 $sampled(retirePc), $time);
    end

    retirePcMatch: assert property (@(posedge clk) disable iff (!arstN)
        (retireValid && expLeft) |-> retirePc == expPc)
    else begin
        errors++;
        $display("[ERROR] %0t retirePc expected %0h got %0h",
                 $time, $sampled(expPc), $sampled(retirePc));
    end

    retireRdMatch: assert property (@(posedge clk) disable iff (!arstN)
        (retireValid && expLeft) |-> retireRd == expRd)
    else begin
        errors++;
        $display("[ERROR] %0t retireRd expected %0d got %0d",
                 $time, $sampled(expRd), $sampled(retireRd));
    end

    retireDataMatch: assert property (@(posedge clk) disable iff (!arstN)
        (retireValid && expLeft) |-> retireData == expData)
    else begin
        errors++;
        $display("[ERROR] %0t retireData expected %h got %h",
                 $time, $sampled(expData), $sampled(retireData));
    end

    // the load-use delay leaves one empty retire slot.
    loadBubble: assert property (@(posedge clk) disable iff (!arstN)
        (retireValid && expLeft && expBubble) |-> !$past(retireValid))
    else begin
        errors++;
        $display("no bubble before the load-use retirement at %0t", $time);
    end

    stallQuiet: assert property (@(posedge clk) disable iff (!arstN)
        stall |-> !retireValid)
    else begin
        errors++;
        $display("retirement while stall was high at %0t", $time);
    end

    // random stall stretches of one to four cycles.
    always @(negedge clk) begin
        if (!arstN) begin
            stall = 1'b0;
        end else if (stallLeft > 0) begin
            stall = 1'b1;
            stallLeft--;
            stallCycles++;
        end else if (($random(seed) & 7) == 0) begin
            stall = 1'b1;
            stallLeft = $random(seed) & 3;
            stallCycles++;
        end else begin
            stall = 1'b0;
        end
    end

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        stall       = 1'b0;
        errors      = 0;
        cycles      = 0;
        stallCycles = 0;
        stallLeft   = 0;
        expCount    = 0;
        expIdx      = 0;
        timedOut    = 1'b0;
        seed        = 78;
        for (int i = 0; i < 4096; i++) begin
            dmem[i] = $random(seed);
        end
        loadProgram();

        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        while (expIdx < expCount && !timedOut) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * expCount + stallCycles + 50) begin
                timedOut = 1'b1;
            end
        end
        // nothing more may retire from the parked loop.
        repeat (10) @(negedge clk);

        if (timedOut) begin
            $display("timeout after %0d cycles with %0d of %0d retirements seen",
                     cycles, expIdx, expCount);
        end
        $display("errors: %0d, retirements: %0d of %0d, stall cycles: %0d",
                 errors, expIdx, expCount, stallCycles);
        if (errors == 0 && !timedOut) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/hazardIf.sv
hdl/hazardController.sv
hdl/decodeUnit.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/coreTop.sv
test/coreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module coreTb -f tb.f -o coreSim > build.log 2>&1 \
    && ./obj_dir/coreSim > sim.log 2>&1

cat build.log sim.log 2> /dev/null
grep -qx "SIMULATION PASSED" sim.log && exit 0 || exit 1
